// File: hdl/icache_pkg.sv
// Shared widths, default sizes and fetch request and response types; import into cache modules
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and default geometry
  ////////////////////////////////////////////////////////////
  localparam int addr_width             = 32;
  localparam int word_width             = 32;
  localparam int default_sets           = 16;
  localparam int default_words_per_line = 4;
  localparam int default_fifo_depth     = 4;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [word_width-1:0] word_t;

  // Request operation
  typedef enum logic
  {
    e_fetch = 1'b0,
    e_fence = 1'b1
  } fetch_op_e;

  ////////////////////////////////////////////////////////////
  // Payloads carried by the FIFOs
  ////////////////////////////////////////////////////////////
  typedef struct packed
  {
    fetch_op_e op;
    addr_t     addr;
  } fetch_req_t;

  // Fence responses carry zero data
  typedef struct packed
  {
    word_t data;
    addr_t addr;
    logic  fence;
  } fetch_resp_t;

endpackage

`default_nettype wire

// File: hdl/fetch_fifo.sv
// Synchronous valid/ready FIFO with a type-parameter payload; one instance per request or response stream
`timescale 1ns/1ps
`default_nettype none

module fetch_fifo
  #(parameter type payload_t = logic [31:0]
    , parameter int depth_p  = 4
    )
  (input  logic     clk_i
   , input  logic     reset_i
   , input  logic     push_valid_i
   , input  payload_t push_data_i
   , output logic     push_ready_o
   , output logic     pop_valid_o
   , output payload_t pop_data_o
   , input  logic     pop_ready_i
   );

  localparam int lg_depth_lp  = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_width_lp = $clog2(depth_p + 1);

  logic [lg_depth_lp-1:0]  rd_ptr_r;
  logic [lg_depth_lp-1:0]  wr_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  payload_t                mem_r [depth_p];
  logic                    push;
  logic                    pop;

  // Pointer wrap at the last entry
  function automatic logic [lg_depth_lp-1:0] next_ptr(input logic [lg_depth_lp-1:0] ptr);
    if (ptr == lg_depth_lp'(depth_p - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_r != cnt_width_lp'(depth_p));
  assign pop_valid_o  = (count_r != '0);
  assign pop_data_o   = mem_r[rd_ptr_r];
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= next_ptr(wr_ptr_r);
      if (pop)
        rd_ptr_r <= next_ptr(rd_ptr_r);
      // Simultaneous push and pop leaves the count alone
      if (push & ~pop)
        count_r <= count_r + 1'b1;
      else if (pop & ~push)
        count_r <= count_r - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wr_ptr_r] <= push_data_i;
  end

endmodule

`default_nettype wire

// File: hdl/icache_lookup.sv
// Two-way lookup stage with tag, data and LRU state; pops fetch requests and pushes responses in order
`timescale 1ns/1ps
`default_nettype none

module icache_lookup
  #(parameter int sets_p             = icache_pkg::default_sets
    , parameter int words_per_line_p = icache_pkg::default_words_per_line
    )
  (input  logic                                           clk_i
   , input  logic                                           reset_i
   , input  logic                                           req_valid_i
   , input  icache_pkg::fetch_req_t                         req_i
   , output logic                                           req_ready_o
   , output logic                                           resp_valid_o
   , output icache_pkg::fetch_resp_t                        resp_o
   , input  logic                                           resp_ready_i
   , output logic                                           refill_start_o
   , output icache_pkg::addr_t                              refill_addr_o
   , input  logic                                           refill_done_i
   , input  icache_pkg::word_t [words_per_line_p-1:0]       refill_line_i
   );

  import icache_pkg::*;

  localparam int line_shift_lp = $clog2(words_per_line_p) + 2;
  localparam int tag_shift_lp  = line_shift_lp + $clog2(sets_p);
  localparam int tag_width_lp  = addr_width - tag_shift_lp;
  localparam int lg_sets_lp    = (sets_p > 1) ? $clog2(sets_p) : 1;
  localparam int lg_words_lp   = (words_per_line_p > 1) ? $clog2(words_per_line_p) : 1;

  typedef logic [tag_width_lp-1:0]       tag_t;
  typedef word_t [words_per_line_p-1:0] line_t;
  typedef enum logic [2:0] {e_idle, e_read, e_compare, e_wait, e_hold} state_e;

  state_e                  state_r;
  state_e                  state_n;
  fetch_req_t              req_r;
  tag_t                    tag_mem [2][sets_p];
  line_t                   data_mem [2][sets_p];
  logic [1:0][sets_p-1:0]  valid_r;
  logic [sets_p-1:0]       lru_r;
  tag_t [1:0]              tag_rd_r;
  line_t [1:0]             line_rd_r;
  logic                    fill_way_r;
  logic [lg_sets_lp-1:0]   set_idx;
  logic [lg_words_lp-1:0]  word_idx;
  tag_t                    req_tag;
  logic [1:0]              way_hit;
  logic                    is_fence;
  logic                    hit;
  logic                    miss;
  logic                    hit_way;
  logic                    repl_way;
  fetch_resp_t             resp_now;

  // Address split: tag, set, word in line
  assign set_idx  = lg_sets_lp'((req_r.addr >> line_shift_lp) & addr_t'(sets_p - 1));
  assign word_idx = lg_words_lp'((req_r.addr >> 2) & addr_t'(words_per_line_p - 1));
  assign req_tag  = tag_t'(req_r.addr >> tag_shift_lp);

  ////////////////////////////////////////////////////////////
  // Compare against the registered array outputs
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    way_hit[0] = valid_r[0][set_idx] & (tag_rd_r[0] == req_tag);
    way_hit[1] = valid_r[1][set_idx] & (tag_rd_r[1] == req_tag);
    is_fence   = (req_r.op == e_fence);
    hit        = ~is_fence & (|way_hit);
    miss       = ~is_fence & ~(|way_hit);
    hit_way    = way_hit[1];
    // An invalid way wins over the LRU choice
    if (~valid_r[0][set_idx])
      repl_way = 1'b0;
    else if (~valid_r[1][set_idx])
      repl_way = 1'b1;
    else
      repl_way = lru_r[set_idx];
    resp_now.data  = is_fence ? '0 : line_rd_r[hit_way][word_idx];
    resp_now.addr  = req_r.addr;
    resp_now.fence = is_fence;
  end

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:    if (req_valid_i) state_n = e_read;
      e_read:    state_n = e_compare;
      e_compare: state_n = miss ? e_wait : (resp_ready_i ? e_idle : e_hold);
      e_wait:    if (refill_done_i) state_n = e_read;
      e_hold:    if (resp_ready_i) state_n = e_idle;
      default:   state_n = e_idle;
    endcase
  end

  // Request and array outputs stay put in hold, so the result does too
  assign req_ready_o    = (state_r == e_idle);
  assign resp_valid_o   = ((state_r == e_compare) & ~miss) | (state_r == e_hold);
  assign resp_o         = resp_now;
  assign refill_start_o = (state_r == e_compare) & miss;
  assign refill_addr_o  = addr_t'((req_r.addr >> line_shift_lp) << line_shift_lp);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_idle;
      valid_r <= '0;
      lru_r   <= '0;
    end
    else
    begin
      state_r <= state_n;
      // Fence drops every line at once
      if ((state_r == e_compare) & is_fence)
        valid_r <= '0;
      // Point LRU at the way that was not used
      if ((state_r == e_compare) & hit)
        lru_r[set_idx] <= ~hit_way;
      if ((state_r == e_wait) & refill_done_i)
        valid_r[fill_way_r][set_idx] <= 1'b1;
    end
  end

  // Request, fill way and synchronous array reads
  always_ff @(posedge clk_i)
  begin
    if (req_ready_o & req_valid_i)
      req_r <= req_i;
    if (state_r == e_read)
    begin
      tag_rd_r[0]  <= tag_mem[0][set_idx];
      tag_rd_r[1]  <= tag_mem[1][set_idx];
      line_rd_r[0] <= data_mem[0][set_idx];
      line_rd_r[1] <= data_mem[1][set_idx];
    end
    if (state_r == e_compare)
      fill_way_r <= repl_way;
    if ((state_r == e_wait) & refill_done_i)
    begin
      tag_mem[fill_way_r][set_idx]  <= req_tag;
      data_mem[fill_way_r][set_idx] <= refill_line_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_refill.sv
// AXI4-Lite read master that fetches one cache line word by word for the lookup stage
`timescale 1ns/1ps
`default_nettype none

module icache_refill
  #(parameter int words_per_line_p = icache_pkg::default_words_per_line
    )
  (input  logic                                     clk_i
   , input  logic                                     reset_i
   , input  logic                                     start_i
   , input  icache_pkg::addr_t                        line_addr_i
   , output logic                                     done_o
   , output icache_pkg::word_t [words_per_line_p-1:0] line_o
   , output icache_pkg::addr_t                        m_axi_araddr_o
   , output logic                                     m_axi_arvalid_o
   , input  logic                                     m_axi_arready_i
   , input  icache_pkg::word_t                        m_axi_rdata_i
   , input  logic                                     m_axi_rvalid_i
   , output logic                                     m_axi_rready_o
   );

  import icache_pkg::*;

  localparam int lg_words_lp = (words_per_line_p > 1) ? $clog2(words_per_line_p) : 1;

  typedef enum logic [1:0] {e_idle, e_ar, e_r} state_e;

  state_e                             state_r;
  logic [lg_words_lp-1:0]             cnt_r;
  logic                               done_r;
  addr_t                              addr_r;
  word_t [words_per_line_p-1:0]       line_r;
  logic                               last_word;

  assign last_word       = (cnt_r == lg_words_lp'(words_per_line_p - 1));
  assign m_axi_araddr_o  = addr_r;
  assign m_axi_arvalid_o = (state_r == e_ar);
  assign m_axi_rready_o  = (state_r == e_r);
  assign done_o          = done_r;
  assign line_o          = line_r;

  ////////////////////////////////////////////////////////////
  // One AR, then one R, per word
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_idle;
      cnt_r   <= '0;
      done_r  <= 1'b0;
    end
    else
    begin
      done_r <= 1'b0;
      case (state_r)
        e_idle:
          if (start_i)
          begin
            cnt_r   <= '0;
            state_r <= e_ar;
          end
        e_ar:
          if (m_axi_arready_i)
            state_r <= e_r;
        e_r:
          if (m_axi_rvalid_i)
          begin
            // Done pulses once the full line is in the register
            if (last_word)
            begin
              state_r <= e_idle;
              done_r  <= 1'b1;
            end
            else
            begin
              cnt_r   <= cnt_r + 1'b1;
              state_r <= e_ar;
            end
          end
        default: state_r <= e_idle;
      endcase
    end
  end

  // Address walk and line assembly
  always_ff @(posedge clk_i)
  begin
    if ((state_r == e_idle) & start_i)
      addr_r <= line_addr_i;
    else if ((state_r == e_r) & m_axi_rvalid_i)
      addr_r <= addr_r + addr_t'(4);
    if ((state_r == e_r) & m_axi_rvalid_i)
      line_r[cnt_r] <= m_axi_rdata_i;
  end

endmodule

`default_nettype wire

// File: hdl/icache_top.sv
// Instruction cache top level; connects request FIFO, lookup stage, refill engine and response FIFO
`timescale 1ns/1ps
`default_nettype none

module icache_top
  #(parameter int sets_p             = icache_pkg::default_sets
    , parameter int words_per_line_p = icache_pkg::default_words_per_line
    , parameter int fifo_depth_p     = icache_pkg::default_fifo_depth
    )
  (input  logic                  clk_i
   , input  logic                  reset_i
   , input  logic                  req_valid_i
   , input  icache_pkg::fetch_op_e req_op_i
   , input  icache_pkg::addr_t     req_addr_i
   , output logic                  req_ready_o
   , output logic                  resp_valid_o
   , output icache_pkg::word_t     resp_data_o
   , output icache_pkg::addr_t     resp_addr_o
   , output logic                  resp_fence_o
   , input  logic                  resp_ready_i
   , output icache_pkg::addr_t     m_axi_araddr_o
   , output logic                  m_axi_arvalid_o
   , input  logic                  m_axi_arready_i
   , input  icache_pkg::word_t     m_axi_rdata_i
   , input  logic                  m_axi_rvalid_i
   , output logic                  m_axi_rready_o
   );

  import icache_pkg::*;

  fetch_req_t                   req_push;
  fetch_req_t                   req_head;
  logic                         req_head_valid;
  logic                         lookup_req_ready;
  fetch_resp_t                  lookup_resp;
  logic                         lookup_resp_valid;
  logic                         resp_fifo_ready;
  fetch_resp_t                  resp_head;
  logic                         refill_start;
  addr_t                        refill_addr;
  logic                         refill_done;
  word_t [words_per_line_p-1:0] refill_line;

  assign req_push.op   = req_op_i;
  assign req_push.addr = req_addr_i;
  assign resp_data_o   = resp_head.data;
  assign resp_addr_o   = resp_head.addr;
  assign resp_fence_o  = resp_head.fence;

  ////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////
  fetch_fifo
    #(.payload_t(fetch_req_t)
      ,.depth_p(fifo_depth_p)
      )
    u_req_fifo
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.push_valid_i(req_valid_i)
       ,.push_data_i(req_push)
       ,.push_ready_o(req_ready_o)
       ,.pop_valid_o(req_head_valid)
       ,.pop_data_o(req_head)
       ,.pop_ready_i(lookup_req_ready)
       );

  icache_lookup
    #(.sets_p(sets_p)
      ,.words_per_line_p(words_per_line_p)
      )
    u_lookup
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.req_valid_i(req_head_valid)
       ,.req_i(req_head)
       ,.req_ready_o(lookup_req_ready)
       ,.resp_valid_o(lookup_resp_valid)
       ,.resp_o(lookup_resp)
       ,.resp_ready_i(resp_fifo_ready)
       ,.refill_start_o(refill_start)
       ,.refill_addr_o(refill_addr)
       ,.refill_done_i(refill_done)
       ,.refill_line_i(refill_line)
       );

  // Miss handling over AXI4-Lite reads
  icache_refill
    #(.words_per_line_p(words_per_line_p)
      )
    u_refill
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.start_i(refill_start)
       ,.line_addr_i(refill_addr)
       ,.done_o(refill_done)
       ,.line_o(refill_line)
       ,.m_axi_araddr_o(m_axi_araddr_o)
       ,.m_axi_arvalid_o(m_axi_arvalid_o)
       ,.m_axi_arready_i(m_axi_arready_i)
       ,.m_axi_rdata_i(m_axi_rdata_i)
       ,.m_axi_rvalid_i(m_axi_rvalid_i)
       ,.m_axi_rready_o(m_axi_rready_o)
       );

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////
  fetch_fifo
    #(.payload_t(fetch_resp_t)
      ,.depth_p(fifo_depth_p)
      )
    u_resp_fifo
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.push_valid_i(lookup_resp_valid)
       ,.push_data_i(lookup_resp)
       ,.push_ready_o(resp_fifo_ready)
       ,.pop_valid_o(resp_valid_o)
       ,.pop_data_o(resp_head)
       ,.pop_ready_i(resp_ready_i)
       );

endmodule

`default_nettype wire

// File: testbench/icache_asserts.sv
// AXI read and response handshake checks for the cache top level; bound into icache_top
`timescale 1ns/1ps
`default_nettype none

module icache_asserts
  (input  logic        clk_i
   , input  logic        reset_i
   , input  logic        resp_valid_i
   , input  logic        resp_ready_i
   , input  logic [31:0] resp_data_i
   , input  logic [31:0] resp_addr_i
   , input  logic        resp_fence_i
   , input  logic        m_axi_arvalid_i
   , input  logic        m_axi_arready_i
   , input  logic [31:0] m_axi_araddr_i
   , input  logic        m_axi_rvalid_i
   , input  logic        m_axi_rready_i
   );

  logic r_pending_r;

  // Set by an AR handshake, cleared by the matching R handshake
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      r_pending_r <= 1'b0;
    else if (m_axi_arvalid_i & m_axi_arready_i)
      r_pending_r <= 1'b1;
    else if (m_axi_rvalid_i & m_axi_rready_i)
      r_pending_r <= 1'b0;
  end

  ar_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    m_axi_arvalid_i && !m_axi_arready_i |=> m_axi_arvalid_i && $stable(m_axi_araddr_i))
    else $error("AR request changed before its handshake");

  resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_data_i)
      && $stable(resp_addr_i) && $stable(resp_fence_i))
    else $error("Response changed while stalled");

  single_read: assert property (@(posedge clk_i) disable iff (reset_i)
    !(r_pending_r && m_axi_arvalid_i))
    else $error("AR issued with a read still outstanding");

endmodule

bind icache_top icache_asserts u_asserts
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.resp_valid_i(resp_valid_o)
   ,.resp_ready_i(resp_ready_i)
   ,.resp_data_i(resp_data_o)
   ,.resp_addr_i(resp_addr_o)
   ,.resp_fence_i(resp_fence_o)
   ,.m_axi_arvalid_i(m_axi_arvalid_o)
   ,.m_axi_arready_i(m_axi_arready_i)
   ,.m_axi_araddr_i(m_axi_araddr_o)
   ,.m_axi_rvalid_i(m_axi_rvalid_i)
   ,.m_axi_rready_i(m_axi_rready_o)
   );

`default_nettype wire

// File: testbench/tb_icache.sv
// Testbench for the instruction cache; drives fetches and fences and checks responses in order
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  import icache_pkg::*;

  localparam int clk_period_lp   = 4;
  localparam int words_lp        = default_words_per_line;
  localparam int max_ar_delay_lp = 3;
  localparam int stream_len_lp   = 40;
  localparam int num_requests_lp = 1 + words_lp + 6 + 3 + stream_len_lp;
  localparam int worst_refill_lp = words_lp * (max_ar_delay_lp + 3) + 8;
  localparam int watchdog_ns_lp  = num_requests_lp * worst_refill_lp * clk_period_lp * 2;

  logic        clk_i;
  logic        reset_i;
  logic        req_valid_i;
  fetch_op_e   req_op_i;
  addr_t       req_addr_i;
  logic        req_ready_o;
  logic        resp_valid_o;
  word_t       resp_data_o;
  addr_t       resp_addr_o;
  logic        resp_fence_o;
  logic        resp_ready_i;
  addr_t       m_axi_araddr_o;
  logic        m_axi_arvalid_o;
  logic        m_axi_arready_i;
  word_t       m_axi_rdata_i;
  logic        m_axi_rvalid_i;
  logic        m_axi_rready_o;

  int          seed = 54;
  int          generation = 0;
  int          errors = 0;
  int          checks = 0;
  int          ar_count = 0;
  int          resp_count = 0;
  int          req_stalls = 0;
  logic        stall_resp = 1'b0;
  fetch_resp_t exp_q[$];

  icache_top u_dut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.req_valid_i(req_valid_i)
     ,.req_op_i(req_op_i)
     ,.req_addr_i(req_addr_i)
     ,.req_ready_o(req_ready_o)
     ,.resp_valid_o(resp_valid_o)
     ,.resp_data_o(resp_data_o)
     ,.resp_addr_o(resp_addr_o)
     ,.resp_fence_o(resp_fence_o)
     ,.resp_ready_i(resp_ready_i)
     ,.m_axi_araddr_o(m_axi_araddr_o)
     ,.m_axi_arvalid_o(m_axi_arvalid_o)
     ,.m_axi_arready_i(m_axi_arready_i)
     ,.m_axi_rdata_i(m_axi_rdata_i)
     ,.m_axi_rvalid_i(m_axi_rvalid_i)
     ,.m_axi_rready_o(m_axi_rready_o)
     );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  // Memory contents change with every generation
  function automatic word_t mem_word(input addr_t addr, input int gen);
    word_t mix;
    mix = {addr[15:0], addr[31:16]} ^ 32'h6b3a_91c5;
    return mix + word_t'(gen) * 32'h0101_0101;
  endfunction

  function automatic fetch_resp_t expected_resp(input fetch_op_e op, input addr_t addr);
    fetch_resp_t r;
    r.addr  = addr;
    r.fence = (op == e_fence);
    r.data  = (op == e_fence) ? '0 : mem_word(addr, generation);
    return r;
  endfunction

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  // AXI memory; AR accepted after a random delay, one R per AR
  initial
  begin : axi_memory
    addr_t rd_addr;
    int    delay;
    m_axi_arready_i = 1'b0;
    m_axi_rvalid_i  = 1'b0;
    m_axi_rdata_i   = '0;
    forever
    begin
      @(negedge clk_i);
      if (m_axi_arvalid_o === 1'b1)
      begin
        rd_addr = m_axi_araddr_o;
        delay   = $unsigned($random(seed)) % (max_ar_delay_lp + 1);
        repeat (delay) @(negedge clk_i);
        m_axi_arready_i = 1'b1;
        @(negedge clk_i);
        m_axi_arready_i = 1'b0;
        ar_count++;
        m_axi_rdata_i  = mem_word(rd_addr, generation);
        m_axi_rvalid_i = 1'b1;
        while (m_axi_rready_o !== 1'b1) @(negedge clk_i);
        @(negedge clk_i);
        m_axi_rvalid_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response side: ready stalls and in-order comparison
  ////////////////////////////////////////////////////////////
  initial
  begin : compare_responses
    fetch_resp_t exp;
    resp_ready_i = 1'b0;
    forever
    begin
      @(negedge clk_i);
      if (stall_resp)
        resp_ready_i = ($unsigned($random(seed)) % 5) == 0;
      else
        resp_ready_i = 1'b1;
      // Handshake happens on the coming rising edge
      if (resp_valid_o === 1'b1 && resp_ready_i)
      begin
        resp_count++;
        if (exp_q.size() == 0)
        begin
          $display("Unexpected response at address %h with no request outstanding", resp_addr_o);
          errors++;
        end
        else
        begin
          exp = exp_q.pop_front();
          checks++;
          if (resp_addr_o !== exp.addr)
          begin
            $display("ERROR: resp_addr_o is %h, expected %h", resp_addr_o, exp.addr);
            errors++;
          end
          if (resp_data_o !== exp.data)
          begin
            $display("ERROR: resp_data_o is %h, expected %h at %h", resp_data_o, exp.data,
                     exp.addr);
            errors++;
          end
          if (resp_fence_o !== exp.fence)
          begin
            $display("ERROR: resp_fence_o is %h, expected %h", resp_fence_o, exp.fence);
            errors++;
          end
        end
      end
    end
  end

  // Caller sits on a falling edge and returns on one
  task automatic send_req(input fetch_op_e op, input addr_t addr);
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    while (req_ready_o !== 1'b1)
    begin
      req_stalls++;
      @(negedge clk_i);
    end
    exp_q.push_back(expected_resp(op, addr));
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  task automatic fetch_and_count(input addr_t addr, input int exp_ars, input string what);
    int ars_before;
    ars_before = ar_count;
    send_req(e_fetch, addr);
    wait_drain();
    if (ar_count - ars_before != exp_ars)
    begin
      $display("%0s at %h caused %0d AR transfers instead of %0d", what, addr,
               ar_count - ars_before, exp_ars);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before, input int ars_before,
                             input string note);
    $display("Test %0s: %0s, %0d AR transfers %0s", name,
             (errors == errors_before) ? "ok" : "mismatch", ar_count - ars_before, note);
  endtask

  initial
  begin : watchdog
    #(watchdog_ns_lp);
    $display("Timeout after %0d ns with %0d responses outstanding", watchdog_ns_lp,
             exp_q.size());
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin : run_tests
    int    i;
    int    errors_before;
    int    ars_before;
    int    resp_before;
    addr_t addr;
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_op_i    = e_fetch;
    req_addr_i  = '0;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;

    errors_before = errors;
    ars_before    = ar_count;
    if (resp_valid_o !== 1'b0)
    begin
      $display("ERROR: resp_valid_o is %h after reset, expected 0", resp_valid_o);
      errors++;
    end
    if (m_axi_arvalid_o !== 1'b0)
    begin
      $display("ERROR: m_axi_arvalid_o is %h after reset, expected 0", m_axi_arvalid_o);
      errors++;
    end
    if (m_axi_rready_o !== 1'b0)
    begin
      $display("ERROR: m_axi_rready_o is %h after reset, expected 0", m_axi_rready_o);
      errors++;
    end
    if (req_ready_o !== 1'b1)
    begin
      $display("ERROR: req_ready_o is %h after reset, expected 1", req_ready_o);
      errors++;
    end
    finish_test("reset state", errors_before, ars_before, "");

    // One line in set 0
    errors_before = errors;
    ars_before    = ar_count;
    fetch_and_count(32'h0000_0100, words_lp, "first fetch");
    for (i = 1; i < words_lp; i++)
      fetch_and_count(addr_t'(32'h0000_0100 + 4 * i), 0, "repeat fetch");
    finish_test("cold miss", errors_before, ars_before, "");

    // Three lines in set 5
    errors_before = errors;
    ars_before    = ar_count;
    fetch_and_count(32'h0000_1050, words_lp, "line A");
    fetch_and_count(32'h0000_2054, words_lp, "line B");
    fetch_and_count(32'h0000_1058, 0, "line A again");
    fetch_and_count(32'h0000_305c, words_lp, "line C");
    fetch_and_count(32'h0000_1050, 0, "line A kept");
    fetch_and_count(32'h0000_2050, words_lp, "line B evicted");
    finish_test("lru replacement", errors_before, ars_before, "");

    errors_before = errors;
    ars_before    = ar_count;
    fetch_and_count(32'h0000_4090, words_lp, "line before fence");
    send_req(e_fence, 32'h0000_4090);
    wait_drain();
    generation++;
    fetch_and_count(32'h0000_4098, words_lp, "line after fence");
    finish_test("fence", errors_before, ars_before, "");

    // Random stream over eight sets with two tags each
    errors_before = errors;
    ars_before    = ar_count;
    resp_before   = resp_count;
    req_stalls    = 0;
    stall_resp    = 1'b1;
    for (i = 0; i < stream_len_lp; i++)
    begin
      addr = addr_t'(((1 + ($unsigned($random(seed)) % 2)) << 12)
                     | (($unsigned($random(seed)) % 8) << 4)
                     | (($unsigned($random(seed)) % words_lp) << 2));
      send_req(e_fetch, addr);
    end
    wait_drain();
    stall_resp = 1'b0;
    if (resp_count - resp_before != stream_len_lp)
    begin
      $display("Stream returned %0d responses for %0d requests", resp_count - resp_before,
               stream_len_lp);
      errors++;
    end
    finish_test("back-pressure", errors_before, ars_before,
                $sformatf("(%0d cycles with req_ready_o low)", req_stalls));

    repeat (4) @(negedge clk_i);
    $display("Summary: %0d responses checked, %0d AR transfers, %0d errors", checks, ar_count,
             errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hdl/icache_pkg.sv
hdl/fetch_fifo.sv
hdl/icache_lookup.sv
hdl/icache_refill.sv
hdl/icache_top.sv
testbench/icache_asserts.sv
testbench/tb_icache.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 -Mdir obj_dir
TOP       = tb_icache
FILELIST  = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
